// File: rtl/tcdm_config.svh
`ifndef TCDM_CONFIG_SVH
`define TCDM_CONFIG_SVH

// channels per initiator group, one bank each
`define TCDM_NB_CHAN 4

// word address inside one bank
`define TCDM_ADDR_W 8

// data word width, a whole number of bytes
`define TCDM_DATA_W 32

`define TCDM_ID_W 4 // transaction id carried to the response
`define TCDM_USER_W 2 // sideband, echoed on reads

// starvation limit and counter width
`define TCDM_STALL_W 8

`endif // TCDM_CONFIG_SVH

// File: rtl/tcdm_pkg.sv
`default_nettype none

package tcdm_pkg;

  `include "tcdm_config.svh"

  // byte lanes per data word
  localparam int unsigned TCDM_BE_W = `TCDM_DATA_W / 8;

  // plain vectors with a meaning
  typedef logic [`TCDM_ADDR_W-1:0]  tcdm_addr_t;  // word address in a bank
  typedef logic [`TCDM_DATA_W-1:0]  tcdm_data_t;
  typedef logic [TCDM_BE_W-1:0]     tcdm_be_t;    // one bit per byte lane
  typedef logic [`TCDM_ID_W-1:0]    tcdm_id_t;
  typedef logic [`TCDM_USER_W-1:0]  tcdm_user_t;
  typedef logic [`TCDM_STALL_W-1:0] tcdm_stall_t; // limit and counter

  // request channel, initiator to memory
  // fields held by the initiator until gnt
  typedef struct packed {
    logic       req;  // request strobe
    tcdm_addr_t add;
    logic       wen;  // low for write, high for read
    tcdm_be_t   be;
    tcdm_data_t data; // write data
    tcdm_id_t   id;
    tcdm_user_t user;
  } tcdm_req_t;

  // response channel, memory to initiator
  typedef struct packed {
    logic       gnt;    // same cycle as req
    tcdm_data_t r_data; // one cycle after a granted read
    tcdm_id_t   r_id;
    tcdm_user_t r_user;
  } tcdm_rsp_t;

  // runtime arbiter control
  typedef struct packed {
    tcdm_stall_t low_prio_max_stall; // 0 disables the starvation counter
    logic        swap_prio;          // 1 puts the low group in front
  } arb_ctrl_t;

endpackage : tcdm_pkg

`default_nettype wire

// File: rtl/tcdm_arbiter.sv
`default_nettype none

`include "tcdm_config.svh"

module tcdm_arbiter
  import tcdm_pkg::*;
#(
  parameter int unsigned NB_CHAN = `TCDM_NB_CHAN
)
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      clear,       // sync restart of the stall count
  input  arb_ctrl_t ctrl,

  input  tcdm_req_t in_high_req [NB_CHAN],
  input  tcdm_req_t in_low_req  [NB_CHAN],
  output tcdm_rsp_t in_high_rsp [NB_CHAN],
  output tcdm_rsp_t in_low_rsp  [NB_CHAN],

  output tcdm_req_t out_req     [NB_CHAN], // towards the banks
  input  tcdm_rsp_t out_rsp     [NB_CHAN]
);

  logic [NB_CHAN-1:0] prio_req;     // per channel, priority side
  logic [NB_CHAN-1:0] other_req;    // per channel, non-priority side
  logic [NB_CHAN-1:0] prio_pass;    // priority side wins the channel
  logic [NB_CHAN-1:0] high_pass;    // in_high routed to the bank
  logic               prio_req_any; // after the starvation mask
  logic               other_req_any;
  logic               prio_mask;
  logic               swap;
  tcdm_stall_t        stall_cnt_q;

  assign swap = ctrl.swap_prio;

  // side mapping, swap turns in_low into the priority side
  for (genvar ii = 0; ii < NB_CHAN; ii++)
  begin : gen_side_map
    always_comb
    begin
      if (swap)
      begin
        prio_req[ii]  = in_low_req[ii].req;
        other_req[ii] = in_high_req[ii].req;
      end
      else
      begin
        prio_req[ii]  = in_high_req[ii].req;
        other_req[ii] = in_low_req[ii].req;
      end
    end
  end

  // limit reached, hand one cycle to the other side
  assign prio_mask = (ctrl.low_prio_max_stall != '0) &&
                     (stall_cnt_q >= ctrl.low_prio_max_stall);

  // any-request reduction over all channels
  assign prio_req_any  = (|prio_req) & ~prio_mask;
  assign other_req_any = |other_req;

  // contended cycles counted, anything else restarts
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      stall_cnt_q <= '0;
    else if (clear)
      stall_cnt_q <= '0;
    else if (prio_req_any && other_req_any)
      stall_cnt_q <= stall_cnt_q + tcdm_stall_t'(1);
    else
      stall_cnt_q <= '0; // also drops back right after the mask cycle
  end

  // per channel pass select
  for (genvar ii = 0; ii < NB_CHAN; ii++)
  begin : gen_pass
    assign prio_pass[ii] = prio_req_any & prio_req[ii];
    // back to physical sides
    assign high_pass[ii] = prio_pass[ii] ^ swap;
  end

  // request mux and gnt steering
  for (genvar ii = 0; ii < NB_CHAN; ii++)
  begin : gen_bind
    always_comb
    begin
      in_high_rsp[ii].gnt = 1'b0;
      in_low_rsp[ii].gnt  = 1'b0;
      if (high_pass[ii])
      begin
        out_req[ii]         = in_high_req[ii];
        in_high_rsp[ii].gnt = out_rsp[ii].gnt;
      end
      else
      begin
        out_req[ii]        = in_low_req[ii]; // idle channels land here too
        in_low_rsp[ii].gnt = out_rsp[ii].gnt;
      end
      // responses go to both sides, gnt tells whose they are
      in_high_rsp[ii].r_data = out_rsp[ii].r_data;
      in_low_rsp[ii].r_data  = out_rsp[ii].r_data;
      in_high_rsp[ii].r_id   = out_rsp[ii].r_id;
      in_low_rsp[ii].r_id    = out_rsp[ii].r_id;
      in_high_rsp[ii].r_user = out_rsp[ii].r_user;
      in_low_rsp[ii].r_user  = out_rsp[ii].r_user;
    end
  end

endmodule : tcdm_arbiter

`default_nettype wire

// File: rtl/tcdm_bank.sv
`default_nettype none

`include "tcdm_config.svh"

module tcdm_bank
  import tcdm_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  tcdm_req_t req,
  output tcdm_rsp_t rsp
);

  localparam int unsigned DEPTH = 2 ** `TCDM_ADDR_W;

  tcdm_data_t mem_q [DEPTH]; // storage array
  tcdm_data_t r_data_q;
  tcdm_id_t   r_id_q;
  tcdm_user_t r_user_q;
  logic       wr_en;
  logic       rd_en;

  // bank never stalls, every req granted at once
  assign wr_en = req.req & ~req.wen;
  assign rd_en = req.req & req.wen;

  // byte-lane merge on writes
  always_ff @(posedge clk_i)
  begin
    if (wr_en)
    begin
      for (int b = 0; b < TCDM_BE_W; b++)
      begin
        if (req.be[b])
          mem_q[req.add][b*8 +: 8] <= req.data[b*8 +: 8];
      end
    end
  end

  // read response, held until the next granted read
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      r_data_q <= '0;
      r_id_q   <= '0;
      r_user_q <= '0;
    end
    else if (rd_en)
    begin
      r_data_q <= mem_q[req.add];
      r_id_q   <= req.id;   // sideband follows the data
      r_user_q <= req.user;
    end
  end

  assign rsp.gnt    = req.req; // combinational grant
  assign rsp.r_data = r_data_q;
  assign rsp.r_id   = r_id_q;
  assign rsp.r_user = r_user_q;

endmodule : tcdm_bank

`default_nettype wire

// File: rtl/tcdm_shallow_top.sv
`default_nettype none

`include "tcdm_config.svh"

module tcdm_shallow_top
  import tcdm_pkg::*;
#(
  parameter int unsigned NB_CHAN = `TCDM_NB_CHAN
)
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      clear,
  input  arb_ctrl_t ctrl,

  // high group, e.g. streamer
  input  tcdm_req_t in_high_req [NB_CHAN],
  output tcdm_rsp_t in_high_rsp [NB_CHAN],

  // low group, e.g. core side
  input  tcdm_req_t in_low_req  [NB_CHAN],
  output tcdm_rsp_t in_low_rsp  [NB_CHAN]
);

  tcdm_req_t bank_req [NB_CHAN]; // arbiter to bank n
  tcdm_rsp_t bank_rsp [NB_CHAN]; // bank n back to arbiter

  // one arbiter for all channels, shared stall counter
  tcdm_arbiter #(
    .NB_CHAN (NB_CHAN)
  ) arb_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .clear       (clear),
    .ctrl        (ctrl),
    .in_high_req (in_high_req),
    .in_low_req  (in_low_req),
    .in_high_rsp (in_high_rsp),
    .in_low_rsp  (in_low_rsp),
    .out_req     (bank_req),
    .out_rsp     (bank_rsp)
  );

  // channel n maps to bank n
  for (genvar ii = 0; ii < NB_CHAN; ii++)
  begin : gen_bank
    tcdm_bank bank_i (
      .clk_i  (clk_i),
      .rst_ni (rst_ni),
      .req    (bank_req[ii]),
      .rsp    (bank_rsp[ii])
    );
  end

endmodule : tcdm_shallow_top

`default_nettype wire

// File: test/tcdm_shallow_chk.sv
`default_nettype none

`include "tcdm_config.svh"

module tcdm_shallow_chk
  import tcdm_pkg::*;
#(
  parameter int unsigned NB_CHAN = `TCDM_NB_CHAN
)
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      clear,
  input  arb_ctrl_t ctrl,
  input  tcdm_req_t in_high_req [NB_CHAN],
  input  tcdm_req_t in_low_req  [NB_CHAN],
  input  tcdm_rsp_t in_high_rsp [NB_CHAN],
  input  tcdm_rsp_t in_low_rsp  [NB_CHAN],
  input  tcdm_req_t out_req     [NB_CHAN],
  input  tcdm_rsp_t out_rsp     [NB_CHAN]
);

  logic [NB_CHAN-1:0] high_v;   // req strobes per side
  logic [NB_CHAN-1:0] low_v;
  logic [NB_CHAN-1:0] exp_high; // in_high expected on the bank
  logic [NB_CHAN-1:0] route_ok;
  logic [NB_CHAN-1:0] gnt_ok;
  logic [NB_CHAN-1:0] bcast_ok;
  logic               masked;   // starvation pass this cycle
  logic               front_any;
  logic               back_any;
  tcdm_stall_t        stall_q;  // reference count of contended cycles

  int unsigned route_fails = 0;
  int unsigned gnt_fails   = 0;
  int unsigned bcast_fails = 0;

  always_comb
  begin
    for (int n = 0; n < NB_CHAN; n++)
    begin
      high_v[n] = in_high_req[n].req;
      low_v[n]  = in_low_req[n].req;
    end
  end

  assign masked    = (ctrl.low_prio_max_stall != '0) && (stall_q >= ctrl.low_prio_max_stall);
  assign front_any = (ctrl.swap_prio ? |low_v : |high_v) && !masked;
  assign back_any  = ctrl.swap_prio ? |high_v : |low_v;

  // counts only while both sides want the memory
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      stall_q <= '0;
    else if (clear || !(front_any && back_any))
      stall_q <= '0;
    else
      stall_q <= stall_q + tcdm_stall_t'(1);
  end

  always_comb
  begin
    for (int n = 0; n < NB_CHAN; n++)
    begin
      // priority side wins its own channel unless masked
      if (ctrl.swap_prio)
        exp_high[n] = !(low_v[n] && !masked);
      else
        exp_high[n] = high_v[n] && !masked;
      route_ok[n] = out_req[n] == (exp_high[n] ? in_high_req[n] : in_low_req[n]);
      gnt_ok[n] = (in_high_rsp[n].gnt == (exp_high[n] && high_v[n])) &&
                  (in_low_rsp[n].gnt == (!exp_high[n] && low_v[n])); // bank grants any req
      bcast_ok[n] =
        ({in_high_rsp[n].r_data, in_high_rsp[n].r_id, in_high_rsp[n].r_user} ==
         {out_rsp[n].r_data, out_rsp[n].r_id, out_rsp[n].r_user}) &&
        ({in_low_rsp[n].r_data, in_low_rsp[n].r_id, in_low_rsp[n].r_user} ==
         {out_rsp[n].r_data, out_rsp[n].r_id, out_rsp[n].r_user});
    end
  end

  a_route: assert property (@(posedge clk_i) disable iff (!rst_ni) &route_ok)
    else
    begin
      route_fails++;
      $error("wrong side routed to a bank, per-channel ok bits %b", route_ok);
    end

  a_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni) &gnt_ok)
    else
    begin
      gnt_fails++;
      $error("gnt steered to the wrong initiator, per-channel ok bits %b", gnt_ok);
    end

  a_bcast: assert property (@(posedge clk_i) disable iff (!rst_ni) &bcast_ok)
    else
    begin
      bcast_fails++;
      $error("response not broadcast unchanged to both sides, ok bits %b", bcast_ok);
    end

endmodule : tcdm_shallow_chk

`default_nettype wire

// File: test/tcdm_shallow_tb.sv
`default_nettype none

`include "tcdm_config.svh"

module tcdm_shallow_tb
  import tcdm_pkg::*;
();

  localparam int unsigned NB_CHAN = `TCDM_NB_CHAN;
  localparam int unsigned PERIOD  = 100;
  localparam int unsigned RST_CYC = 8;
  localparam int unsigned WORDS   = 16;  // address window of the traffic
  localparam int unsigned PHASE   = 40;  // cycles per directed phase
  localparam int unsigned N_RAND  = 400; // random cycles, blocks of 20
  localparam int unsigned N_CYC   = RST_CYC + 1 + WORDS + 4 * PHASE + 1 + N_RAND;

  logic       clk_i;
  logic       rst_ni;
  logic       clear;
  arb_ctrl_t  ctrl;
  tcdm_req_t  high_req [NB_CHAN];
  tcdm_req_t  low_req  [NB_CHAN];
  tcdm_rsp_t  high_rsp [NB_CHAN];
  tcdm_rsp_t  low_rsp  [NB_CHAN];
  logic       high_gnt [NB_CHAN]; // gnt seen in the last cycle
  logic       low_gnt  [NB_CHAN];
  tcdm_data_t shadow   [NB_CHAN][256]; // expected bank contents
  logic       exp_vld  [NB_CHAN];      // read granted, response due
  tcdm_data_t exp_data [NB_CHAN];
  tcdm_id_t   exp_id   [NB_CHAN];
  tcdm_user_t exp_user [NB_CHAN];
  int unsigned errors = 0;
  int unsigned cycles = 0;

  tcdm_shallow_top dut_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .clear       (clear),
    .ctrl        (ctrl),
    .in_high_req (high_req),
    .in_high_rsp (high_rsp),
    .in_low_req  (low_req),
    .in_low_rsp  (low_rsp)
  );

  bind tcdm_arbiter tcdm_shallow_chk #(
    .NB_CHAN (NB_CHAN)
  ) chk_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .clear       (clear),
    .ctrl        (ctrl),
    .in_high_req (in_high_req),
    .in_low_req  (in_low_req),
    .in_high_rsp (in_high_rsp),
    .in_low_rsp  (in_low_rsp),
    .out_req     (out_req),
    .out_rsp     (out_rsp)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #(PERIOD / 2) clk_i = ~clk_i;
  end

  initial
  begin
    #(PERIOD * (N_CYC + 100));
    $display("watchdog expired, test sequence did not finish in time");
    $display("TEST RESULT: FAIL");
    $finish;
  end

  task automatic check(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp)
    begin
      errors++;
      $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  // word written by the fill phase, built from bank and whole address
  function automatic tcdm_data_t fill_word(int unsigned ch, tcdm_addr_t a);
    return {4'hc, 4'(ch), a, ~a, a ^ 8'h5a};
  endfunction

  function automatic tcdm_req_t new_req(int unsigned dens);
    tcdm_req_t r;
    r = '0;
    if ($urandom_range(99, 0) < dens)
    begin
      r.req  = 1'b1;
      r.wen  = 1'($urandom_range(1, 0)); // about half reads
      r.add  = tcdm_addr_t'($urandom_range(WORDS - 1, 0));
      r.be   = tcdm_be_t'($urandom_range(15, 0));
      r.data = $urandom();
      r.id   = tcdm_id_t'($urandom());
      r.user = tcdm_user_t'($urandom());
    end
    return r;
  endfunction

  // a granted request, as the memory rules see it
  task automatic accept(int unsigned ch, tcdm_req_t r);
    if (!r.wen)
    begin
      for (int b = 0; b < TCDM_BE_W; b++)
      begin
        if (r.be[b])
          shadow[ch][r.add][b*8 +: 8] = r.data[b*8 +: 8];
      end
    end
    else
    begin
      exp_vld[ch]  = 1'b1;
      exp_data[ch] = shadow[ch][r.add];
      exp_id[ch]   = r.id;
      exp_user[ch] = r.user;
    end
  endtask

  // one clock, entered at a falling edge with inputs driven
  task automatic cycle();
    #(PERIOD / 4); // gnt settled, rising edge still ahead
    for (int ch = 0; ch < NB_CHAN; ch++)
    begin
      exp_vld[ch]  = 1'b0;
      high_gnt[ch] = high_rsp[ch].gnt;
      low_gnt[ch]  = low_rsp[ch].gnt;
      if (high_gnt[ch])
        accept(ch, high_req[ch]);
      if (low_gnt[ch])
        accept(ch, low_req[ch]);
    end
    @(negedge clk_i);
    cycles++;
    for (int ch = 0; ch < NB_CHAN; ch++)
    begin
      if (exp_vld[ch]) // both sides see the same response
      begin
        check($sformatf("high_rsp[%0d].r_data", ch), high_rsp[ch].r_data, exp_data[ch]);
        check($sformatf("low_rsp[%0d].r_data", ch), low_rsp[ch].r_data, exp_data[ch]);
        check($sformatf("high_rsp[%0d].r_id", ch), 32'(high_rsp[ch].r_id), 32'(exp_id[ch]));
        check($sformatf("low_rsp[%0d].r_id", ch), 32'(low_rsp[ch].r_id), 32'(exp_id[ch]));
        check($sformatf("high_rsp[%0d].r_user", ch), 32'(high_rsp[ch].r_user),
              32'(exp_user[ch]));
        check($sformatf("low_rsp[%0d].r_user", ch), 32'(low_rsp[ch].r_user),
              32'(exp_user[ch]));
      end
    end
  endtask

  // losers hold their request, winners and idle slots draw a new one
  task automatic traffic(int unsigned n, int unsigned dens);
    for (int i = 0; i < n; i++)
    begin
      for (int ch = 0; ch < NB_CHAN; ch++)
      begin
        if (!high_req[ch].req || high_gnt[ch])
          high_req[ch] = new_req(dens);
        if (!low_req[ch].req || low_gnt[ch])
          low_req[ch] = new_req(dens);
      end
      cycle();
    end
  endtask

  initial
  begin
    int unsigned asserts;
    void'($urandom(87));
    rst_ni = 1'b0;
    clear  = 1'b0;
    ctrl   = '0;
    for (int ch = 0; ch < NB_CHAN; ch++)
    begin
      high_req[ch] = '0;
      low_req[ch]  = '0;
      high_gnt[ch] = 1'b0;
      low_gnt[ch]  = 1'b0;
    end
    repeat (RST_CYC) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    for (int ch = 0; ch < NB_CHAN; ch++) // idle after reset
    begin
      check($sformatf("high_rsp[%0d].gnt", ch), 32'(high_rsp[ch].gnt), 32'h0);
      check($sformatf("low_rsp[%0d].gnt", ch), 32'(low_rsp[ch].gnt), 32'h0);
      check($sformatf("high_rsp[%0d].r_id", ch), 32'(high_rsp[ch].r_id), 32'h0);
      check($sformatf("low_rsp[%0d].r_id", ch), 32'(low_rsp[ch].r_id), 32'h0);
    end
    for (int a = 0; a < WORDS; a++) // full-word fill, in_high alone
    begin
      for (int ch = 0; ch < NB_CHAN; ch++)
      begin
        high_req[ch] = '0;
        high_req[ch].req  = 1'b1;
        high_req[ch].add  = tcdm_addr_t'(a);
        high_req[ch].be   = '1;
        high_req[ch].data = fill_word(ch, tcdm_addr_t'(a));
      end
      cycle();
    end
    traffic(PHASE, 70); // fixed priority, in_high in front
    ctrl.swap_prio = 1'b1;
    traffic(PHASE, 70);
    ctrl.swap_prio = 1'b0;
    ctrl.low_prio_max_stall = tcdm_stall_t'(3); // full contention from here
    traffic(PHASE, 100);
    clear = 1'b1; // count restarts mid-stream
    traffic(1, 100);
    clear = 1'b0;
    ctrl.swap_prio = 1'b1;
    ctrl.low_prio_max_stall = tcdm_stall_t'(1); // in_high through every other cycle
    traffic(PHASE, 100);
    for (int blk = 0; blk < N_RAND / 20; blk++)
    begin
      ctrl.swap_prio = 1'($urandom_range(1, 0));
      ctrl.low_prio_max_stall = tcdm_stall_t'($urandom_range(4, 0));
      clear = 1'($urandom_range(3, 0) == 0);
      traffic(1, 80);
      clear = 1'b0;
      traffic(19, 50 + $urandom_range(50, 0));
    end
    asserts = dut_i.arb_i.chk_i.route_fails + dut_i.arb_i.chk_i.gnt_fails +
              dut_i.arb_i.chk_i.bcast_fails;
    $display("%0d cycles run, %0d mismatches, %0d assertion failures",
             cycles, errors, asserts);
    if (errors == 0 && asserts == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule : tcdm_shallow_tb

`default_nettype wire

// File: src.f
+incdir+rtl
rtl/tcdm_pkg.sv
rtl/tcdm_arbiter.sv
rtl/tcdm_bank.sv
rtl/tcdm_shallow_top.sv
test/tcdm_shallow_chk.sv
test/tcdm_shallow_tb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tcdm_shallow_tb
FILELIST  := src.f
BUILD_DIR := obj_dir
RUN_FLAGS := +verilator+error+limit+1000
LOG       := sim.log

SOURCES := $(wildcard rtl/*.sv rtl/*.svh test/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS) 2>&1 | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "TEST RESULT: PASS" $(LOG); then echo "no result line in $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
